// File: verilog/memif_settings.svh
`ifndef MEMIF_SETTINGS_SVH
`define MEMIF_SETTINGS_SVH

// Pixel word on the controller user port
`define MEMIF_WORD_BITS 128
`define MEMIF_BYTES_PER_WORD 16

// Words per burst command
// The external controller is built for this burst length
`define MEMIF_BURST_LENGTH 16
`define MEMIF_BYTES_PER_CMD (`MEMIF_BYTES_PER_WORD * `MEMIF_BURST_LENGTH)

// Bytes per frame, four bursts here
// A UXGA frame at 16 bpp would be 1600*1200*2
// Must stay a multiple of MEMIF_BYTES_PER_CMD
`define MEMIF_FRAME_BYTES 1024

// Controller byte address
`define MEMIF_ADDR_BITS 30

`endif

// File: verilog/memif_pkg.sv
`default_nettype none

`include "memif_settings.svh"

package memif_pkg;

    //////////////////////////////
    // Data and address types
    //////////////////////////////

    // One pixel word, as moved through both controller FIFOs
    typedef logic [`MEMIF_WORD_BITS-1:0] pix_word_t;

    // Byte address on the command port
    typedef logic [`MEMIF_ADDR_BITS-1:0] byte_addr_t;

    // Words sitting in the write FIFO, not yet covered by a command
    typedef logic [6:0] burst_count_t;

    //////////////////////////////
    // Command encoding
    //////////////////////////////

    typedef enum logic [2:0] {
        CMD_WRITE = 3'd0,
        CMD_READ  = 3'd1
    } cmd_instr_e;

endpackage

`default_nettype wire

// File: verilog/burst_writer.sv
`default_nettype none

`include "memif_settings.svh"

module burst_writer (
    input  logic                  clk_mif,
    input  logic                  rst_n,
    input  logic                  calib_done,
    input  logic                  vsync,
    // Pixel input stream
    input  memif_pkg::pix_word_t  pix_write,
    input  logic                  pix_write_valid,
    output logic                  pix_write_ready,
    // Controller write-data FIFO
    output logic                  wr_en,
    output memif_pkg::pix_word_t  wr_data,
    input  logic                  wr_full,
    // Burst write request towards the arbiter
    output logic                  wr_issue_req,
    output memif_pkg::byte_addr_t wr_byte_addr,
    input  logic                  wr_issue_done
);

    localparam memif_pkg::burst_count_t burst_words =
        memif_pkg::burst_count_t'(`MEMIF_BURST_LENGTH);
    localparam memif_pkg::byte_addr_t cmd_step =
        memif_pkg::byte_addr_t'(`MEMIF_BYTES_PER_CMD);
    localparam memif_pkg::byte_addr_t last_addr =
        memif_pkg::byte_addr_t'(`MEMIF_FRAME_BYTES - `MEMIF_BYTES_PER_CMD);

    typedef enum logic [1:0] {
        st_idle,
        st_push,
        st_issue
    } wr_state_t;

    wr_state_t               state;
    memif_pkg::burst_count_t burst_count;
    logic                    sys_rst;
    logic                    pix_accept;

    // Controller not calibrated counts as reset
    assign sys_rst = !rst_n || !calib_done;

    // Pixels only taken inside a frame and while the FIFO has room
    assign pix_write_ready = (state != st_idle) && pix_write_valid && !wr_full;
    assign pix_accept = pix_write_ready;

    assign wr_issue_req = (state == st_issue);

    //////////////////////////////
    // Burst FSM
    //////////////////////////////

    always_ff @(posedge clk_mif) begin
        if (sys_rst) begin
            state <= st_idle;
            burst_count <= '0;
            wr_byte_addr <= '0;
        end else begin
            case (state)
                st_idle: begin
                    // New frame starts at address zero
                    if (vsync) begin
                        wr_byte_addr <= '0;
                        burst_count <= '0;
                        state <= st_push;
                    end
                end
                st_push: begin
                    // One burst buffered, hand it to the arbiter
                    if (burst_count >= burst_words) begin
                        burst_count <= burst_count
                            + memif_pkg::burst_count_t'(pix_accept) - burst_words;
                        state <= st_issue;
                    end else begin
                        burst_count <= burst_count + memif_pkg::burst_count_t'(pix_accept);
                    end
                end
                st_issue: begin
                    // Pixels keep arriving while the command waits
                    burst_count <= burst_count + memif_pkg::burst_count_t'(pix_accept);
                    if (wr_issue_done) begin
                        wr_byte_addr <= wr_byte_addr + cmd_step;
                        state <= (wr_byte_addr == last_addr) ? st_idle : st_push;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    //////////////////////////////
    // Write FIFO push
    //////////////////////////////

    // Enable and data land together one cycle after acceptance
    always_ff @(posedge clk_mif) begin
        if (sys_rst) begin
            wr_en <= 1'b0;
        end else begin
            wr_en <= pix_accept;
        end
    end

    always_ff @(posedge clk_mif) begin
        if (pix_accept) begin
            wr_data <= pix_write;
        end
    end

endmodule

`default_nettype wire

// File: verilog/cmd_arbiter.sv
`default_nettype none

module cmd_arbiter (
    input  logic                  clk_mif,
    input  logic                  rst_n,
    input  logic                  calib_done,
    // Read requester
    input  logic                  rd_issue_req,
    input  memif_pkg::byte_addr_t rd_byte_addr,
    output logic                  rd_issue_done,
    // Write requester
    input  logic                  wr_issue_req,
    input  memif_pkg::byte_addr_t wr_byte_addr,
    output logic                  wr_issue_done,
    // Controller command port
    output logic                  cmd_en,
    output memif_pkg::cmd_instr_e cmd_instr,
    output memif_pkg::byte_addr_t cmd_byte_addr,
    input  logic                  cmd_full
);

    typedef enum logic {
        st_wait,
        st_act
    } issue_state_t;

    issue_state_t state;
    logic         sys_rst;
    logic         rd_grant;
    logic         wr_grant;
    logic         issue_now;

    assign sys_rst = !rst_n || !calib_done;

    // Reads win, no round robin
    assign rd_grant = !cmd_full && rd_issue_req;
    // A write must stay behind the read pointer so old data gets read first
    assign wr_grant = !cmd_full && !rd_issue_req && wr_issue_req
        && (wr_byte_addr < rd_byte_addr);
    assign issue_now = (state == st_wait) && (rd_grant || wr_grant);

    //////////////////////////////
    // Issue FSM
    //////////////////////////////

    // One command, then one idle cycle while the requester drops its level
    always_ff @(posedge clk_mif) begin
        if (sys_rst) begin
            state <= st_wait;
            cmd_en <= 1'b0;
            rd_issue_done <= 1'b0;
            wr_issue_done <= 1'b0;
        end else begin
            case (state)
                st_wait: begin
                    if (issue_now) begin
                        cmd_en <= 1'b1;
                        rd_issue_done <= rd_grant;
                        wr_issue_done <= wr_grant;
                        state <= st_act;
                    end
                end
                st_act: begin
                    cmd_en <= 1'b0;
                    rd_issue_done <= 1'b0;
                    wr_issue_done <= 1'b0;
                    state <= st_wait;
                end
                default: state <= st_wait;
            endcase
        end
    end

    // Command fields captured with the grant
    always_ff @(posedge clk_mif) begin
        if (issue_now) begin
            cmd_instr <= rd_grant ? memif_pkg::CMD_READ : memif_pkg::CMD_WRITE;
            cmd_byte_addr <= rd_grant ? rd_byte_addr : wr_byte_addr;
        end
    end

endmodule

`default_nettype wire

// File: verilog/burst_reader.sv
`default_nettype none

`include "memif_settings.svh"

module burst_reader (
    input  logic                  clk_mif,
    input  logic                  rst_n,
    input  logic                  calib_done,
    input  logic                  vsync,
    // Pixel output stream
    output memif_pkg::pix_word_t  pix_read,
    output logic                  pix_read_valid,
    input  logic                  pix_read_ready,
    // Controller read-data FIFO
    output logic                  rd_en,
    input  memif_pkg::pix_word_t  rd_data,
    input  logic                  rd_empty,
    // Burst read request towards the arbiter
    output logic                  rd_issue_req,
    output memif_pkg::byte_addr_t rd_byte_addr,
    input  logic                  rd_issue_done
);

    localparam memif_pkg::byte_addr_t cmd_step =
        memif_pkg::byte_addr_t'(`MEMIF_BYTES_PER_CMD);
    localparam memif_pkg::byte_addr_t last_addr =
        memif_pkg::byte_addr_t'(`MEMIF_FRAME_BYTES - `MEMIF_BYTES_PER_CMD);

    typedef enum logic [1:0] {
        st_idle,
        st_wait_data,
        st_wait_drain,
        st_issue
    } rd_state_t;

    rd_state_t state;
    logic      sys_rst;
    logic      pix_reading;

    assign sys_rst = !rst_n || !calib_done;

    // Straight pass-through, back-pressure leaves words in the FIFO
    assign pix_reading = !rd_empty && pix_read_ready;
    assign rd_en = pix_reading;
    assign pix_read_valid = pix_reading;
    assign pix_read = rd_data;

    assign rd_issue_req = (state == st_issue);

    //////////////////////////////
    // Read FSM
    //////////////////////////////

    always_ff @(posedge clk_mif) begin
        if (sys_rst) begin
            state <= st_idle;
            rd_byte_addr <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (vsync) begin
                        rd_byte_addr <= '0;
                        state <= st_wait_drain;
                    end
                end
                // Burst in flight until its first word shows up
                st_wait_data: begin
                    if (!rd_empty) begin
                        state <= st_wait_drain;
                    end
                end
                // Next burst only once the previous one is gone
                st_wait_drain: begin
                    if (pix_read_ready && rd_empty) begin
                        state <= st_issue;
                    end
                end
                st_issue: begin
                    if (rd_issue_done) begin
                        rd_byte_addr <= rd_byte_addr + cmd_step;
                        state <= (rd_byte_addr == last_addr) ? st_idle : st_wait_data;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: verilog/memif.sv
`default_nettype none

module memif (
    input  logic                  clk_mif,
    input  logic                  rst_n,
    input  logic                  calib_done,
    input  logic                  vsync,
    // Pixel input stream
    input  memif_pkg::pix_word_t  pix_write,
    input  logic                  pix_write_valid,
    output logic                  pix_write_ready,
    // Pixel output stream
    output memif_pkg::pix_word_t  pix_read,
    output logic                  pix_read_valid,
    input  logic                  pix_read_ready,
    // Controller command port
    output logic                  cmd_en,
    output memif_pkg::cmd_instr_e cmd_instr,
    output memif_pkg::byte_addr_t cmd_byte_addr,
    input  logic                  cmd_full,
    // Controller write-data FIFO
    output logic                  wr_en,
    output memif_pkg::pix_word_t  wr_data,
    input  logic                  wr_full,
    // Controller read-data FIFO
    output logic                  rd_en,
    input  memif_pkg::pix_word_t  rd_data,
    input  logic                  rd_empty
);

    //////////////////////////////
    // Requests to the arbiter
    //////////////////////////////

    logic                  wr_issue_req;
    logic                  wr_issue_done;
    memif_pkg::byte_addr_t wr_byte_addr;
    logic                  rd_issue_req;
    logic                  rd_issue_done;
    memif_pkg::byte_addr_t rd_byte_addr;

    // Input side, fills the write FIFO
    burst_writer u_burst_writer (
        .clk_mif         (clk_mif),
        .rst_n           (rst_n),
        .calib_done      (calib_done),
        .vsync           (vsync),
        .pix_write       (pix_write),
        .pix_write_valid (pix_write_valid),
        .pix_write_ready (pix_write_ready),
        .wr_en           (wr_en),
        .wr_data         (wr_data),
        .wr_full         (wr_full),
        .wr_issue_req    (wr_issue_req),
        .wr_byte_addr    (wr_byte_addr),
        .wr_issue_done   (wr_issue_done)
    );

    // Shared command port
    cmd_arbiter u_cmd_arbiter (
        .clk_mif       (clk_mif),
        .rst_n         (rst_n),
        .calib_done    (calib_done),
        .rd_issue_req  (rd_issue_req),
        .rd_byte_addr  (rd_byte_addr),
        .rd_issue_done (rd_issue_done),
        .wr_issue_req  (wr_issue_req),
        .wr_byte_addr  (wr_byte_addr),
        .wr_issue_done (wr_issue_done),
        .cmd_en        (cmd_en),
        .cmd_instr     (cmd_instr),
        .cmd_byte_addr (cmd_byte_addr),
        .cmd_full      (cmd_full)
    );

    // Output side, drains the read FIFO
    burst_reader u_burst_reader (
        .clk_mif        (clk_mif),
        .rst_n          (rst_n),
        .calib_done     (calib_done),
        .vsync          (vsync),
        .pix_read       (pix_read),
        .pix_read_valid (pix_read_valid),
        .pix_read_ready (pix_read_ready),
        .rd_en          (rd_en),
        .rd_data        (rd_data),
        .rd_empty       (rd_empty),
        .rd_issue_req   (rd_issue_req),
        .rd_byte_addr   (rd_byte_addr),
        .rd_issue_done  (rd_issue_done)
    );

endmodule

`default_nettype wire

// File: test/clk_gen.sv
`default_nettype none

module clk_gen #(
    parameter real period_ns    = 8.0,
    parameter int  reset_cycles = 3
) (
    output logic clk_mif,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 1ps;

    // Free running clock
    initial begin
        clk_mif = 1'b0;
        forever #(period_ns / 2.0) clk_mif = ~clk_mif;
    end

    // Reset held low for a few rising edges, released on an edge
    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk_mif);
        rst_n <= 1'b1;
    end

endmodule

`default_nettype wire

// File: test/memif_asserts.sv
`default_nettype none

module memif_asserts (
    input logic clk_mif,
    input logic rst_n,
    input logic calib_done,
    input logic cmd_en,
    input logic pix_write_valid,
    input logic pix_write_ready,
    input logic wr_full,
    input logic wr_en,
    input logic pix_read_valid,
    input logic rd_empty
);
    timeunit 1ns;
    timeprecision 1ps;

    // Read by the testbench top at the end of the run
    int unsigned fail_count = 0;
    logic        in_reset;

    // Uncalibrated controller counts as reset, same as in the design
    assign in_reset = !rst_n || !calib_done;

    //////////////////////////////
    // Command port
    //////////////////////////////

    // Arbiter idles one cycle after every command
    cmd_spacing: assert property (@(posedge clk_mif) disable iff (in_reset)
        cmd_en |=> !cmd_en)
    else begin
        $error("cmd_en high on two cycles in a row");
        fail_count++;
    end

    //////////////////////////////
    // FIFO sides
    //////////////////////////////

    write_room: assert property (@(posedge clk_mif) disable iff (in_reset)
        pix_write_ready |-> !wr_full)
    else begin
        $error("pix_write_ready high while wr_full");
        fail_count++;
    end

    read_data_present: assert property (@(posedge clk_mif) disable iff (in_reset)
        pix_read_valid |-> !rd_empty)
    else begin
        $error("pix_read_valid high while rd_empty");
        fail_count++;
    end

    // Push lags acceptance by exactly one cycle, both directions
    push_after_accept: assert property (@(posedge clk_mif) disable iff (in_reset)
        (pix_write_valid && pix_write_ready) |=> wr_en)
    else begin
        $error("accepted pixel not pushed on the next cycle");
        fail_count++;
    end

    push_only_after_accept: assert property (@(posedge clk_mif) disable iff (in_reset)
        wr_en |-> $past(pix_write_valid && pix_write_ready))
    else begin
        $error("wr_en without a pixel accepted on the cycle before");
        fail_count++;
    end

endmodule

`default_nettype wire

// File: test/memif_tb.sv
`default_nettype none

`include "memif_settings.svh"

module memif_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int frame_words      = `MEMIF_FRAME_BYTES / `MEMIF_BYTES_PER_WORD;
    localparam int burst_words      = `MEMIF_BURST_LENGTH;
    localparam int bursts_per_frame = frame_words / burst_words;
    localparam int cmd_bytes        = `MEMIF_BYTES_PER_CMD;
    localparam int num_frames       = 3;
    // About 100 cycles per output word covers random stalls plus reset and idle phase
    localparam int max_cycles       = num_frames * frame_words * 100 + 800;

    //////////////////////////////
    // DUT signals
    //////////////////////////////

    logic                  clk_mif;
    logic                  rst_n;
    logic                  calib_done;
    logic                  vsync;
    memif_pkg::pix_word_t  pix_write = '0;
    logic                  pix_write_valid = 1'b0;
    logic                  pix_write_ready;
    memif_pkg::pix_word_t  pix_read;
    logic                  pix_read_valid;
    logic                  pix_read_ready;
    logic                  cmd_en;
    memif_pkg::cmd_instr_e cmd_instr;
    memif_pkg::byte_addr_t cmd_byte_addr;
    logic                  cmd_full;
    logic                  wr_en;
    memif_pkg::pix_word_t  wr_data;
    logic                  wr_full;
    logic                  rd_en;
    memif_pkg::pix_word_t  rd_data = '0;
    logic                  rd_empty = 1'b1;

    // Controller model state
    memif_pkg::pix_word_t mem [frame_words];
    memif_pkg::pix_word_t wr_fifo [$];
    memif_pkg::pix_word_t rd_fifo [$];
    logic                 full_at_last_edge = 1'b0;

    // Progress counters and results
    int rd_cmds = 0;
    int wr_cmds = 0;
    int words_out = 0;
    int pix_accepted = 0;
    int pix_budget = 0;
    int frames_started = 0;
    int cycle_count = 0;
    int check_count = 0;
    int error_count = 0;
    logic write_coin = 1'b0;

    clk_gen #(.period_ns(8.0), .reset_cycles(3)) u_clk_gen (
        .clk_mif (clk_mif),
        .rst_n   (rst_n)
    );

    memif UUT (.*);

    bind memif memif_asserts u_asserts (
        .clk_mif         (clk_mif),
        .rst_n           (rst_n),
        .calib_done      (calib_done),
        .cmd_en          (cmd_en),
        .pix_write_valid (pix_write_valid),
        .pix_write_ready (pix_write_ready),
        .wr_full         (wr_full),
        .wr_en           (wr_en),
        .pix_read_valid  (pix_read_valid),
        .rd_empty        (rd_empty)
    );

    //////////////////////////////
    // Data patterns
    //////////////////////////////

    // Power-up memory contents where every field depends on the whole index
    function automatic memif_pkg::pix_word_t init_word(input int index);
        return {32'h5eed_0000 ^ 32'(index), ~32'(index),
                32'(index) * 32'h9e37_79b1, (32'(index) << 7) | 32'h0000_0051};
    endfunction

    // Word the source sends as pixel index of a frame
    function automatic memif_pkg::pix_word_t pixel_value(input int frame, input int index);
        return {16'hf00d, 16'(frame), 32'(index),
                (32'(frame * frame_words + index) * 32'h0101_0101) ^ 32'ha5a5_0000,
                ~32'(frame * 1000 + index)};
    endfunction

    // Reads of an address come before its write so frame n shows frame n-1
    function automatic memif_pkg::pix_word_t expected_pixel(input int frame, input int index);
        if (frame == 0) begin
            return init_word(index);
        end
        return pixel_value(frame - 1, index);
    endfunction

    //////////////////////////////
    // Check helpers
    //////////////////////////////

    task automatic compare_value(input string name, input logic [127:0] got,
                                 input logic [127:0] exp);
        check_count++;
        assert (got === exp) else begin
            error_count++;
            $display("FAILED t=%0t %s: expected %h, got %h", $time, name, exp, got);
        end
    endtask

    task automatic expect_low(input string name, input logic got);
        check_count++;
        assert (got === 1'b0) else begin
            error_count++;
            $display("FAILED t=%0t %s: expected 0, got %b", $time, name, got);
        end
    endtask

    task automatic expect_idle_outputs();
        expect_low("cmd_en", cmd_en);
        expect_low("wr_en", wr_en);
        expect_low("pix_write_ready", pix_write_ready);
        expect_low("pix_read_valid", pix_read_valid);
    endtask

    task automatic report_test(input int num, input string name, input int errs_before);
        $display("test %0d, %s: finished with %0d error(s)", num, name,
                 error_count - errs_before);
    endtask

    //////////////////////////////
    // Controller model
    //////////////////////////////

    initial begin
        for (int i = 0; i < frame_words; i++) begin
            mem[i] = init_word(i);
        end
    end

    always @(posedge clk_mif) begin : controller_model
        int word_base;
        int reads_in_frame;
        if (wr_en) begin
            wr_fifo.push_back(wr_data);
        end
        if (rd_en) begin
            check_count++;
            assert (rd_fifo.size() > 0) else begin
                error_count++;
                $display("Read FIFO popped at %0t while it was empty", $time);
            end
            if (rd_fifo.size() > 0) begin
                void'(rd_fifo.pop_front());
            end
        end
        if (cmd_en) begin
            check_count++;
            assert (!full_at_last_edge && frames_started > 0) else begin
                error_count++;
                $display("Command at %0t issued under cmd_full or before any vsync", $time);
            end
            word_base = int'(cmd_byte_addr) / `MEMIF_BYTES_PER_WORD;
            if (cmd_instr == memif_pkg::CMD_READ) begin
                // Reads walk the frame linearly
                compare_value("cmd_byte_addr", cmd_byte_addr,
                              (rd_cmds % bursts_per_frame) * cmd_bytes);
                for (int k = 0; k < burst_words; k++) begin
                    rd_fifo.push_back(mem[(word_base + k) % frame_words]);
                end
                rd_cmds++;
            end else begin
                compare_value("cmd_byte_addr", cmd_byte_addr,
                              (wr_cmds % bursts_per_frame) * cmd_bytes);
                // Reads already issued in the frame this write belongs to
                reads_in_frame = rd_cmds - (wr_cmds / bursts_per_frame) * bursts_per_frame;
                check_count++;
                assert (int'(cmd_byte_addr) < reads_in_frame * cmd_bytes) else begin
                    error_count++;
                    $display("Write to %h at %0t came before the read of that burst",
                             cmd_byte_addr, $time);
                end
                check_count++;
                assert (wr_fifo.size() >= burst_words) else begin
                    error_count++;
                    $display("Write command at %0t with only %0d words buffered",
                             $time, wr_fifo.size());
                end
                for (int k = 0; k < burst_words; k++) begin
                    if (wr_fifo.size() > 0) begin
                        mem[(word_base + k) % frame_words] = wr_fifo.pop_front();
                    end
                end
                wr_cmds++;
            end
        end
        // Arbiter decides on the value seen one edge before cmd_en
        full_at_last_edge = cmd_full;
        // First-word-fall-through read FIFO
        rd_empty <= (rd_fifo.size() == 0);
        rd_data <= (rd_fifo.size() > 0) ? rd_fifo[0] : '0;
    end

    //////////////////////////////
    // Stimulus
    //////////////////////////////

    // All random draws in one seeded process
    initial begin : random_inputs
        void'($urandom(32'hb59));
        pix_read_ready = 1'b0;
        cmd_full = 1'b0;
        wr_full = 1'b0;
        forever begin
            @(posedge clk_mif);
            pix_read_ready <= ($urandom % 4) != 0;
            cmd_full <= ($urandom % 4) == 0;
            wr_full <= ($urandom % 8) == 0;
            write_coin <= ($urandom % 4) != 0;
        end
    end

    // Pixel source sending the next word of the running frame
    always @(posedge clk_mif) begin : drive_pixels
        int next_count;
        next_count = pix_accepted;
        if (pix_write_valid && pix_write_ready) begin
            next_count = pix_accepted + 1;
        end
        pix_accepted <= next_count;
        pix_write <= pixel_value(next_count / frame_words, next_count % frame_words);
        pix_write_valid <= (next_count < pix_budget) && write_coin;
    end

    //////////////////////////////
    // Output comparison
    //////////////////////////////

    always @(posedge clk_mif) begin : compare_output
        memif_pkg::pix_word_t exp_word;
        if (pix_read_valid) begin
            check_count++;
            assert (words_out < frames_started * frame_words) else begin
                error_count++;
                $display("Output word %0d at %0t arrived outside any started frame",
                         words_out, $time);
            end
            exp_word = expected_pixel(words_out / frame_words, words_out % frame_words);
            compare_value("pix_read", pix_read, exp_word);
            words_out++;
        end
    end

    // Run limit
    always @(posedge clk_mif) begin : watchdog
        cycle_count++;
        if (cycle_count >= max_cycles) begin
            $display("Timeout: run reached %0d cycles before all frames finished", max_cycles);
            $display("%0d checks, %0d errors", check_count, error_count);
            $display("Test failures found");
            $finish;
        end
    end

    //////////////////////////////
    // Test sequence
    //////////////////////////////

    task automatic wait_frame_end(input int f);
        do begin
            @(negedge clk_mif);
        end while (!(words_out >= (f + 1) * frame_words
                     && rd_cmds >= (f + 1) * bursts_per_frame
                     && wr_cmds >= (f + 1) * bursts_per_frame));
    endtask

    task automatic verify_frame_memory(input int f);
        for (int i = 0; i < frame_words; i++) begin
            compare_value("mem", mem[i], pixel_value(f, i));
        end
        check_count++;
        assert (wr_fifo.size() == 0 && rd_fifo.size() == 0) else begin
            error_count++;
            $display("Controller FIFOs not empty after frame %0d", f);
        end
    endtask

    task automatic run_frame(input int f);
        int errs_before;
        errs_before = error_count;
        @(posedge clk_mif);
        vsync <= 1'b1;
        frames_started <= f + 1;
        pix_budget <= (f + 1) * frame_words;
        @(posedge clk_mif);
        vsync <= 1'b0;
        wait_frame_end(f);
        compare_value("words_out", words_out, (f + 1) * frame_words);
        verify_frame_memory(f);
        report_test(f + 2, $sformatf("frame %0d", f), errs_before);
    endtask

    initial begin : run_tests
        int errs_before;
        int total_errors;
        calib_done = 1'b0;
        vsync = 1'b0;
        @(posedge rst_n);

        // Controller still calibrating and then calibrated without vsync
        // Pixels of frame 0 already on offer so an early ready would show
        errs_before = error_count;
        pix_budget <= frame_words;
        repeat (10) begin
            @(negedge clk_mif);
            expect_idle_outputs();
        end
        @(posedge clk_mif);
        calib_done <= 1'b1;
        repeat (20) begin
            @(negedge clk_mif);
            expect_idle_outputs();
        end
        report_test(1, "idle after reset", errs_before);

        for (int f = 0; f < num_frames; f++) begin
            run_frame(f);
        end

        // Nothing extra may trickle out after the last frame
        // Pixels beyond the last frame are offered and must stay untaken
        errs_before = error_count;
        pix_budget <= (num_frames + 1) * frame_words;
        repeat (20) begin
            @(negedge clk_mif);
            expect_low("pix_write_ready", pix_write_ready);
        end
        compare_value("words_out", words_out, num_frames * frame_words);
        compare_value("rd_cmds", rd_cmds, num_frames * bursts_per_frame);
        compare_value("wr_cmds", wr_cmds, num_frames * bursts_per_frame);
        compare_value("pix_accepted", pix_accepted, num_frames * frame_words);
        report_test(num_frames + 2, "stream totals", errs_before);

        total_errors = error_count + UUT.u_asserts.fail_count;
        $display("%0d checks, %0d errors, %0d assertion failures", check_count,
                 error_count, UUT.u_asserts.fail_count);
        if (total_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
+incdir+verilog
verilog/memif_pkg.sv
verilog/burst_writer.sv
verilog/cmd_arbiter.sv
verilog/burst_reader.sv
verilog/memif.sv
test/clk_gen.sv
test/memif_asserts.sv
test/memif_tb.sv

// File: Bender.yml
package:
  name: memif

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/memif_pkg.sv
      - verilog/burst_writer.sv
      - verilog/cmd_arbiter.sv
      - verilog/burst_reader.sv
      - verilog/memif.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - test/clk_gen.sv
      - test/memif_asserts.sv
      - test/memif_tb.sv
